// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = icache_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -o $(TOP)

# The log decides the result, the simulator exit status is not trusted
run: build
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

lint:
	$(SIM) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/icache_mem_model.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_mem_model #(
    parameter logic [`ICACHE_ADDR_W-1:0] KEY  = 32'h0,
    parameter logic [31:0]               SEED = 32'd1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
    input  logic                      mem_req_valid,
    output logic [`ICACHE_ADDR_W-1:0] mem_rsp_data = '0,
    output logic                      mem_rsp_ready = 1'b0
);

    logic [31:0] rng_state = SEED;
    logic [2:0]  wait_left;
    logic        counting; // A delay has been drawn for the open request

    // LCG, upper bits give the 0 to 7 cycle delay
    function automatic logic [2:0] pick_delay();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[18:16];
    endfunction

    always @(posedge clk)
    begin : respond
        logic [2:0] delay;
        if (rst)
        begin
            mem_rsp_ready <= 1'b0;
            mem_rsp_data  <= '0;
            counting      <= 1'b0;
            wait_left     <= 3'd0;
        end
        else if (mem_rsp_ready)
        begin
            mem_rsp_ready <= 1'b0; // Word taken on this edge
            counting      <= 1'b0;
        end
        else if (mem_req_valid)
        begin
            delay = counting ? wait_left : pick_delay();
            if (delay == 3'd0)
            begin
                mem_rsp_ready <= 1'b1;
                mem_rsp_data  <= {mem_req_addr[`ICACHE_ADDR_W-1:2], 2'b00} ^ KEY;
            end
            else
            begin
                wait_left <= delay - 3'd1;
                counting  <= 1'b1;
            end
        end
    end

endmodule

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;

    localparam logic [`ICACHE_ADDR_W-1:0] MEM_KEY = 32'h5a3c_96e1;
    localparam logic [`ICACHE_ADDR_W-1:0] BASE    = 32'h0000_4000;
    localparam int                        TIMEOUT = 6000; // 400 accesses of up to 13 cycles

    logic                      clk;
    logic                      rst;
    logic                      flush;
    logic [`ICACHE_ADDR_W-1:0] cpu_req_addr;
    logic                      cpu_req_valid;
    logic [`ICACHE_ADDR_W-1:0] cpu_rsp_data;
    logic                      cpu_rsp_ready;
    logic [`ICACHE_ADDR_W-1:0] mem_req_addr;
    logic                      mem_req_valid;
    logic [`ICACHE_ADDR_W-1:0] mem_rsp_data;
    logic                      mem_rsp_ready;

    logic                      expect_hit;
    logic                      expect_miss;
    logic                      mem_seen;   // Memory was asked during the current access
    logic [`ICACHE_ADDR_W-1:0] mem_addr_q;
    logic [`ICACHE_ADDR_W-1:0] exp_word;
    logic [31:0]               rng_state;
    int                        cycles = 0;
    int                        errors = 0;
    int                        errors_at_start = 0;
    int                        tests = 0;
    int                        accesses = 0;
    string                     test_name = "reset";

    icache_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_rsp_data  (cpu_rsp_data),
        .cpu_rsp_ready (cpu_rsp_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_ready (mem_rsp_ready)
    );

    icache_mem_model #(.KEY(MEM_KEY), .SEED(32'd38992)) u_mem (
        .clk           (clk),
        .rst           (rst),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_ready (mem_rsp_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory holds the word at the aligned address xor the key
    assign exp_word = {cpu_req_addr[`ICACHE_ADDR_W-1:2], 2'b00} ^ MEM_KEY;

    always @(posedge clk)
    begin
        mem_addr_q <= mem_req_addr;
        if (rst || !cpu_req_valid)
        begin
            mem_seen <= 1'b0;
        end
        else if (mem_req_valid)
        begin
            mem_seen <= 1'b1;
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("Timeout after %0d cycles in test %s, the cache stopped answering",
                     cycles, test_name);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    a_rsp_data: assert property (
        @(posedge clk) disable iff (rst)
        cpu_rsp_ready |-> cpu_rsp_data == exp_word
    ) else
    begin
        errors = errors + 1;
        $display("CHECK FAILED %s: cpu_rsp_data expected %h actual %h",
                 test_name, $sampled(exp_word), $sampled(cpu_rsp_data));
    end

    a_mem_addr: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid |-> mem_req_addr == cpu_req_addr
    ) else
    begin
        errors = errors + 1;
        $display("CHECK FAILED %s: mem_req_addr expected %h actual %h",
                 test_name, $sampled(cpu_req_addr), $sampled(mem_req_addr));
    end

    // Request held steady while memory stalls
    a_mem_hold: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid && !mem_rsp_ready |=> mem_req_valid && mem_req_addr == mem_addr_q
    ) else
    begin
        errors = errors + 1;
        $display("CHECK FAILED %s: held request expected valid 1 addr %h actual valid %b addr %h",
                 test_name, $sampled(mem_addr_q), $sampled(mem_req_valid),
                 $sampled(mem_req_addr));
    end

    a_rsp_with_req: assert property (
        @(posedge clk) disable iff (rst)
        cpu_rsp_ready |-> cpu_req_valid
    ) else
    begin
        errors = errors + 1;
        $display("Test %s: cpu_rsp_ready came while no CPU request was pending", test_name);
    end

    a_hit_latency: assert property (
        @(posedge clk) disable iff (rst)
        $rose(cpu_req_valid) && expect_hit |=> cpu_rsp_ready
    ) else
    begin
        errors = errors + 1;
        $display("CHECK FAILED %s: cpu_rsp_ready 2 cycles after request expected 1 actual %b",
                 test_name, $sampled(cpu_rsp_ready));
    end

    a_mem_used: assert property (
        @(posedge clk) disable iff (rst)
        cpu_rsp_ready && (expect_hit || expect_miss) |-> mem_seen == expect_miss
    ) else
    begin
        errors = errors + 1;
        $display("CHECK FAILED %s: memory request seen expected %b actual %b",
                 test_name, $sampled(expect_miss), $sampled(mem_seen));
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 16;
    endfunction

    // Called on a rising edge, returns one idle cycle after the response
    task automatic access(input logic [31:0] addr, input logic want_hit, input logic want_miss);
        cpu_req_addr  <= addr;
        cpu_req_valid <= 1'b1;
        expect_hit    <= want_hit;
        expect_miss   <= want_miss;
        @(posedge clk);
        while (!cpu_rsp_ready)
        begin
            @(posedge clk);
        end
        cpu_req_valid <= 1'b0;
        expect_hit    <= 1'b0;
        expect_miss   <= 1'b0;
        accesses = accesses + 1;
        @(posedge clk);
    endtask

    task automatic pulse_flush();
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests = tests + 1;
        $display("%-12s done, %0d errors", test_name, errors - errors_at_start);
    endtask

    initial
    begin
        rst           = 1'b1;
        flush         = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_valid = 1'b0;
        expect_hit    = 1'b0;
        expect_miss   = 1'b0;
        rng_state     = 32'd38992;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        start_test("cold_miss");
        for (int i = 0; i < `ICACHE_LINES; i++) access(BASE + 32'(i * 4), 1'b0, 1'b1);
        finish_test();

        start_test("hit");
        for (int i = 0; i < `ICACHE_LINES; i++) access(BASE + 32'(i * 4), 1'b1, 1'b0);
        finish_test();

        // Same index 3, tags differ in bit 6
        start_test("conflict");
        for (int i = 0; i < 8; i++) access(BASE + 32'h100c + ((i % 2 == 1) ? 32'h40 : 32'h0),
                                           1'b0, 1'b1);
        finish_test();

        start_test("flush");
        pulse_flush();
        for (int i = 0; i < `ICACHE_LINES; i++) access(BASE + 32'(i * 4), 1'b0, 1'b1);
        finish_test();

        start_test("stall");
        for (int i = 0; i < 20; i++) access(32'h0008_0000 + 32'(i * 'h44), 1'b0, 1'b1);
        finish_test();

        // 64 words over 16 lines gives a mix of hits and conflicts
        start_test("random");
        for (int i = 0; i < 300; i++) access(BASE + ((next_random() % 32'd64) << 2), 1'b0, 1'b0);
        finish_test();

        repeat (2) @(posedge clk);
        $display("%0d tests, %0d accesses, %0d checks failed", tests, accesses, errors);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/icache_addr_pkg.sv
source/icache_store_pkg.sv
source/icache_if.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_ctrl.sv
source/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

// ==== source/icache_addr_pkg.sv ====
`include "icache_defs.svh"

package icache_addr_pkg;

    typedef logic [`ICACHE_TAG_W-1:0] icache_tag_t;
    typedef logic [`ICACHE_IDX_W-1:0] icache_idx_t;

    // Field view used for the lookup
    typedef struct packed {
        icache_tag_t                 tag;
        icache_idx_t                 idx;
        logic [`ICACHE_OFF_W-1:0]    off; // Ignored, lines hold a single word
    } icache_addr_fields_t;

    // The same address word seen raw (memory request) or split (lookup)
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0]   raw;
        icache_addr_fields_t         f;
    } icache_addr_t;

endpackage

// ==== source/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  icache_addr_pkg::icache_addr_t cpu_req_addr,
    input  logic                          cpu_req_valid,
    output logic [`ICACHE_ADDR_W-1:0]     cpu_rsp_data,
    output logic                          cpu_rsp_ready,
    output icache_addr_pkg::icache_addr_t mem_req_addr,
    output logic                          mem_req_valid,
    input  logic [`ICACHE_ADDR_W-1:0]     mem_rsp_data,
    input  logic                          mem_rsp_ready,
    icache_tag_if.ctrl                    tag,
    icache_data_if.ctrl                   data
);
    import icache_addr_pkg::*;
    import icache_store_pkg::*;

    icache_state_t state;
    icache_state_t state_nxt;
    icache_addr_t  req_q;      // Request address captured when leaving IDLE
    icache_idx_t   lookup_idx;
    logic          hit;
    logic          refill;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && cpu_req_valid)
        begin
            req_q <= cpu_req_addr;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:     if (cpu_req_valid) state_nxt = COMPARE;
            COMPARE:  state_nxt = hit ? IDLE : ALLOCATE;
            ALLOCATE: if (mem_rsp_ready) state_nxt = REFILL;
            REFILL:   state_nxt = COMPARE;
            default:  state_nxt = IDLE;
        endcase
    end

    // In IDLE the lookup starts straight from the CPU address, saving a cycle on hits
    assign lookup_idx   = (state == IDLE) ? cpu_req_addr.f.idx : req_q.f.idx;
    assign tag.rd_idx   = lookup_idx;
    assign data.rd_idx  = lookup_idx;

    assign hit = tag.rd_entry.valid && (tag.rd_entry.tag == req_q.f.tag);

    assign cpu_rsp_ready = (state == COMPARE) && hit;
    assign cpu_rsp_data  = data.rd_word;

    assign mem_req_valid    = (state == ALLOCATE);
    assign mem_req_addr.raw = req_q.raw; // Memory sees the whole word

    // Tag and word go in on the same edge that accepts the memory data
    assign refill         = mem_req_valid && mem_rsp_ready;
    assign tag.wr_en      = refill;
    assign tag.wr_idx     = req_q.f.idx;
    assign tag.wr_entry   = '{valid: 1'b1, tag: req_q.f.tag};
    assign data.wr_en     = refill;
    assign data.wr_idx    = req_q.f.idx;
    assign data.wr_word   = mem_rsp_data;

    // The second lookup after a refill must find the line just written
    a_refill_then_hit: assert property (
        @(posedge clk) disable iff (rst)
        state == REFILL |=> cpu_rsp_ready
    ) else $error("ctrl: refilled line did not hit on the second lookup");

    // The response must land while the CPU still holds its request
    a_rsp_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        cpu_rsp_ready |-> cpu_req_valid
    ) else $error("ctrl: response without a pending CPU request");

    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid && !mem_rsp_ready |=> mem_req_valid && $stable(mem_req_addr)
    ) else $error("ctrl: memory request changed before it was accepted");

endmodule

// ==== source/icache_data_array.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_data_array (
    input  logic         clk,
    icache_data_if.array data
);

    logic [`ICACHE_ADDR_W-1:0] words [`ICACHE_LINES];

    always_ff @(posedge clk)
    begin
        if (data.wr_en)
        begin
            words[data.wr_idx] <= data.wr_word;
        end
    end

    // Looked up alongside the tag array, so same read latency
    always_ff @(posedge clk)
    begin
        data.rd_word <= words[data.rd_idx];
    end

endmodule

// ==== source/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Address and instruction word width
`define ICACHE_ADDR_W 32

// Direct mapped with one word per line
`define ICACHE_LINES 16

// Address split, tag | index | byte offset
`define ICACHE_IDX_W 4
`define ICACHE_TAG_W 26
`define ICACHE_OFF_W 2

`endif

// ==== source/icache_if.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

// Controller to tag array
interface icache_tag_if;
    import icache_addr_pkg::*;
    import icache_store_pkg::*;

    icache_idx_t   rd_idx;
    icache_entry_t rd_entry; // One cycle after rd_idx
    logic          wr_en;
    icache_idx_t   wr_idx;
    icache_entry_t wr_entry;

    modport ctrl (
        output rd_idx, wr_en, wr_idx, wr_entry,
        input  rd_entry
    );

    modport array (
        input  rd_idx, wr_en, wr_idx, wr_entry,
        output rd_entry
    );
endinterface

// Controller to data array
interface icache_data_if;
    import icache_addr_pkg::*;

    icache_idx_t               rd_idx;
    logic [`ICACHE_ADDR_W-1:0] rd_word; // One cycle after rd_idx
    logic                      wr_en;
    icache_idx_t               wr_idx;
    logic [`ICACHE_ADDR_W-1:0] wr_word;

    modport ctrl (
        output rd_idx, wr_en, wr_idx, wr_word,
        input  rd_word
    );

    modport array (
        input  rd_idx, wr_en, wr_idx, wr_word,
        output rd_word
    );
endinterface

// ==== source/icache_store_pkg.sv ====
package icache_store_pkg;

    // One tag store entry, valid bit on top
    typedef struct packed {
        logic                        valid;
        icache_addr_pkg::icache_tag_t tag;
    } icache_entry_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0, // Waiting for a CPU request
        COMPARE  = 2'd1, // Array outputs are valid, check for a hit
        ALLOCATE = 2'd2, // Memory read outstanding
        REFILL   = 2'd3  // Line written, look it up again
    } icache_state_t;

endpackage

// ==== source/icache_tag_array.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tag_array (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    icache_tag_if.array tag
);
    import icache_addr_pkg::*;
    import icache_store_pkg::*;

    logic [`ICACHE_LINES-1:0] valid;
    icache_tag_t              tags [`ICACHE_LINES];

    // Valid bits are the only state that needs clearing
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            valid <= '0;
        end
        else if (tag.wr_en)
        begin
            valid[tag.wr_idx] <= tag.wr_entry.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tag.wr_en)
        begin
            tags[tag.wr_idx] <= tag.wr_entry.tag;
        end
    end

    // Registered read, old contents on a same-cycle write
    always_ff @(posedge clk)
    begin
        tag.rd_entry.valid <= valid[tag.rd_idx];
        tag.rd_entry.tag   <= tags[tag.rd_idx];
    end

    // A flush must not land in the middle of a refill
    a_no_flush_on_refill: assert property (
        @(posedge clk) disable iff (rst)
        !(tag.wr_en && flush)
    ) else $error("tag array: refill write coincides with flush");

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic [`ICACHE_ADDR_W-1:0] cpu_req_addr,
    input  logic                      cpu_req_valid,
    output logic [`ICACHE_ADDR_W-1:0] cpu_rsp_data,
    output logic                      cpu_rsp_ready,
    output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
    output logic                      mem_req_valid,
    input  logic [`ICACHE_ADDR_W-1:0] mem_rsp_data,
    input  logic                      mem_rsp_ready
);

    icache_tag_if  tag_if ();
    icache_data_if data_if ();

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_rsp_data  (cpu_rsp_data),
        .cpu_rsp_ready (cpu_rsp_ready),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_ready (mem_rsp_ready),
        .tag           (tag_if.ctrl),
        .data          (data_if.ctrl)
    );

    icache_tag_array u_tag_array (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .tag   (tag_if.array)
    );

    icache_data_array u_data_array (
        .clk  (clk),
        .data (data_if.array)
    );

endmodule
